// ==== common/procyon_defs.svh ====
// ########################################
// Bus and cache line widths shared by the
// design and the testbench. Include where needed
// ########################################

`ifndef PROCYON_DEFS_SVH
`define PROCYON_DEFS_SVH

// Wishbone data bus width in bits
`define WB_DATA_WIDTH 32

// Wishbone byte address width
`define WB_ADDR_WIDTH 32

// Data cache line width in bits
`define DC_LINE_WIDTH 128

// CPU byte address width
`define ADDR_WIDTH 32

`endif

// ==== common/procyon_pkg.sv ====
// ########################################
// Vector types for the cache memory path.
// Import wherever the types are needed
// ########################################

`include "procyon_defs.svh"

package procyon_pkg;

    // One word on the Wishbone data bus
    typedef logic [`WB_DATA_WIDTH-1:0] wb_data_t;

    // Wishbone byte address
    typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;

    // One select bit per byte lane
    typedef logic [`WB_DATA_WIDTH/8-1:0] wb_byte_select_t;

    // Byte address as seen by the CPU and cache
    typedef logic [`ADDR_WIDTH-1:0] procyon_addr_t;

    // A whole data cache line, lowest address in the low bits
    typedef logic [`DC_LINE_WIDTH-1:0] procyon_cacheline_t;

endpackage

// ==== common/biu_if.sv ====
// ########################################
// Request and response bundle between the
// CCU and the Wishbone bus interface unit
// ########################################

`timescale 1ns/100ps

`include "procyon_defs.svh"

interface biu_if;
    import procyon_pkg::*;

    // Request, held stable by the CCU while en is high
    logic               en;
    logic               we;
    procyon_addr_t      addr;
    procyon_cacheline_t wdata;

    // Response, done stays up until en drops
    procyon_cacheline_t rdata;
    logic               busy;
    logic               done;

    modport ccu (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  busy,
        input  done
    );

    modport biu (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output busy,
        output done
    );

endinterface

// ==== ccu/ccu_arb.sv ====
// ########################################
// Cache control unit. Queues one fill and one
// writeback and serves the writeback first
// ########################################

`timescale 1ns/100ps

`include "procyon_defs.svh"

module ccu_arb (
    input  logic                            i_wb_clk,
    input  logic                            i_wb_rst,

    // Line fill request from the cache
    input  logic                            i_fill_req,
    input  procyon_pkg::procyon_addr_t      i_fill_addr,

    // Victim writeback request from the cache
    input  logic                            i_victim_req,
    input  procyon_pkg::procyon_addr_t      i_victim_addr,
    input  procyon_pkg::procyon_cacheline_t i_victim_data,

    // Fill completion
    output logic                            o_fill_busy,
    output logic                            o_fill_valid,
    output procyon_pkg::procyon_addr_t      o_fill_addr,
    output procyon_pkg::procyon_cacheline_t o_fill_data,

    // Writeback completion
    output logic                            o_victim_busy,
    output logic                            o_victim_done,

    // Towards the bus interface unit
    biu_if.ccu                              biu
);
    import procyon_pkg::*;

    // Byte offset bits inside one line
    localparam int LINE_OFFSET_BITS = $clog2(`DC_LINE_WIDTH/8);

    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        WAIT_DONE = 2'b01,
        RETIRE    = 2'b10
    } arb_state_t;

    arb_state_t         state_q;
    arb_state_t         next_state;

    logic               fill_pend_q;
    logic               victim_pend_q;
    logic               serve_victim_q;
    procyon_addr_t      fill_addr_q;
    procyon_addr_t      victim_addr_q;
    procyon_cacheline_t victim_data_q;
    procyon_cacheline_t fill_data_q;

    logic               fill_accept;
    logic               victim_accept;
    logic               start;
    logic               finish;

    // A pulse is dropped while its class already has a pending request
    assign fill_accept   = i_fill_req & ~fill_pend_q;
    assign victim_accept = i_victim_req & ~victim_pend_q;

    assign start  = (state_q == IDLE) & (fill_pend_q | victim_pend_q);
    assign finish = (state_q == WAIT_DONE) & biu.done;

    always_comb begin
        next_state = state_q;
        case (state_q)
            IDLE:      next_state = start ? WAIT_DONE : IDLE;
            WAIT_DONE: next_state = biu.done ? RETIRE : WAIT_DONE;
            RETIRE:    next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= next_state;
        end
    end

    // Pending flags clear as the transfer finishes so busy
    // falls together with the completion pulse
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            fill_pend_q   <= 1'b0;
            victim_pend_q <= 1'b0;
        end else begin
            if (fill_accept) begin
                fill_pend_q <= 1'b1;
            end else if (finish & ~serve_victim_q) begin
                fill_pend_q <= 1'b0;
            end

            if (victim_accept) begin
                victim_pend_q <= 1'b1;
            end else if (finish & serve_victim_q) begin
                victim_pend_q <= 1'b0;
            end
        end
    end

    // Captured requests with addresses aligned to the line
    always_ff @(posedge i_wb_clk) begin
        if (fill_accept) begin
            fill_addr_q <= {i_fill_addr[`ADDR_WIDTH-1:LINE_OFFSET_BITS],
                            {LINE_OFFSET_BITS{1'b0}}};
        end
        if (victim_accept) begin
            victim_addr_q <= {i_victim_addr[`ADDR_WIDTH-1:LINE_OFFSET_BITS],
                              {LINE_OFFSET_BITS{1'b0}}};
            victim_data_q <= i_victim_data;
        end
    end

    // Writeback wins so a later fill of the same line sees the new data
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            serve_victim_q <= 1'b0;
        end else if (start) begin
            serve_victim_q <= victim_pend_q;
        end
    end

    // Completion pulses one cycle after done
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            o_fill_valid  <= 1'b0;
            o_victim_done <= 1'b0;
        end else begin
            o_fill_valid  <= finish & ~serve_victim_q;
            o_victim_done <= finish & serve_victim_q;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (finish & ~serve_victim_q) begin
            fill_data_q <= biu.rdata;
        end
    end

    assign o_fill_busy   = fill_pend_q;
    assign o_victim_busy = victim_pend_q;
    assign o_fill_addr   = fill_addr_q;
    assign o_fill_data   = fill_data_q;

    // Request held stable for the whole transfer until en drops after done
    // A writeback accepted during a fill must not disturb the write data
    assign biu.en    = (state_q == WAIT_DONE);
    assign biu.we    = serve_victim_q;
    assign biu.addr  = serve_victim_q ? victim_addr_q : fill_addr_q;
    assign biu.wdata = serve_victim_q ? victim_data_q : '0;

endmodule

// ==== wb_biu/wb_biu.sv ====
// ########################################
// Wishbone pipelined master. Moves one cache
// line as four beats for the CCU
// ########################################

`timescale 1ns/100ps

`include "procyon_defs.svh"

module wb_biu (
    input  logic                             i_wb_clk,
    input  logic                             i_wb_rst,

    // Wishbone master port
    input  logic                             i_wb_ack,
    input  logic                             i_wb_stall,
    input  procyon_pkg::wb_data_t            i_wb_data,
    output logic                             o_wb_cyc,
    output logic                             o_wb_stb,
    output logic                             o_wb_we,
    output procyon_pkg::wb_byte_select_t     o_wb_sel,
    output procyon_pkg::wb_addr_t            o_wb_addr,
    output procyon_pkg::wb_data_t            o_wb_data,

    // Requests from the CCU
    biu_if.biu                               biu
);
    import procyon_pkg::*;

    localparam int BEATS          = `DC_LINE_WIDTH / `WB_DATA_WIDTH;
    localparam int BYTES_PER_BEAT = `WB_DATA_WIDTH / 8;
    localparam int IDX_WIDTH      = $clog2(BEATS);

    // Counts need one extra bit to hold the full beat count
    typedef logic [IDX_WIDTH:0]   beat_cnt_t;
    typedef logic [IDX_WIDTH-1:0] beat_idx_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        REQS = 2'b01,
        ACKS = 2'b10,
        DONE = 2'b11
    } biu_state_t;

    biu_state_t         state_q;
    biu_state_t         next_state;

    beat_cnt_t          num_reqs;
    beat_cnt_t          num_acks;
    beat_idx_t          req_idx;
    beat_idx_t          ack_idx;
    procyon_cacheline_t line_q;

    logic               in_progress;
    logic               requesting;
    logic               ack_valid;

    assign in_progress = (state_q == REQS) | (state_q == ACKS);

    // A beat goes out only when the slave is not stalling
    assign requesting = (state_q == REQS) & ~i_wb_stall;

    // Acks count in REQS as well, beats overlap under stall
    assign ack_valid = i_wb_ack & in_progress;

    always_comb begin
        next_state = state_q;
        case (state_q)
            IDLE: begin
                if (biu.en) begin
                    next_state = REQS;
                end
            end
            REQS: begin
                if (requesting && (num_reqs == beat_cnt_t'(1))) begin
                    next_state = ACKS;
                end
            end
            ACKS: begin
                if (ack_valid && (num_acks == beat_cnt_t'(1))) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                if (!biu.en) begin
                    next_state = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= next_state;
        end
    end

    // Remaining beats and the current indices, reloaded in IDLE
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst || (state_q == IDLE)) begin
            num_reqs <= beat_cnt_t'(BEATS);
            num_acks <= beat_cnt_t'(BEATS);
            req_idx  <= '0;
            ack_idx  <= '0;
        end else begin
            num_reqs <= num_reqs - beat_cnt_t'(requesting);
            num_acks <= num_acks - beat_cnt_t'(ack_valid);
            req_idx  <= req_idx + beat_idx_t'(requesting);
            ack_idx  <= ack_idx + beat_idx_t'(ack_valid);
        end
    end

    // Returning words land in order of the acks
    always_ff @(posedge i_wb_clk) begin
        if (ack_valid) begin
            line_q[ack_idx*`WB_DATA_WIDTH +: `WB_DATA_WIDTH] <= i_wb_data;
        end
    end

    assign biu.rdata = line_q;
    assign biu.busy  = in_progress;
    assign biu.done  = (state_q == DONE);

    assign o_wb_cyc  = in_progress;
    assign o_wb_stb  = (state_q == REQS);
    assign o_wb_we   = biu.we;
    assign o_wb_sel  = '1;

    // Address and data follow the request index, held while stalled
    assign o_wb_addr = wb_addr_t'(biu.addr)
                     + (wb_addr_t'(req_idx) * wb_addr_t'(BYTES_PER_BEAT));

    always_comb begin
        o_wb_data = biu.wdata[req_idx*`WB_DATA_WIDTH +: `WB_DATA_WIDTH];
    end

endmodule

// ==== verilog/ccu_top.sv ====
// ########################################
// Memory side of the data cache. Joins the
// CCU to the Wishbone bus interface unit
// ########################################

`timescale 1ns/100ps

module ccu_top (
    input  logic                             i_wb_clk,
    input  logic                             i_wb_rst,

    // Cache side
    input  logic                             i_fill_req,
    input  procyon_pkg::procyon_addr_t       i_fill_addr,
    input  logic                             i_victim_req,
    input  procyon_pkg::procyon_addr_t       i_victim_addr,
    input  procyon_pkg::procyon_cacheline_t  i_victim_data,
    output logic                             o_fill_busy,
    output logic                             o_fill_valid,
    output procyon_pkg::procyon_addr_t       o_fill_addr,
    output procyon_pkg::procyon_cacheline_t  o_fill_data,
    output logic                             o_victim_busy,
    output logic                             o_victim_done,

    // Wishbone master
    input  logic                             i_wb_ack,
    input  logic                             i_wb_stall,
    input  procyon_pkg::wb_data_t            i_wb_data,
    output logic                             o_wb_cyc,
    output logic                             o_wb_stb,
    output logic                             o_wb_we,
    output procyon_pkg::wb_byte_select_t     o_wb_sel,
    output procyon_pkg::wb_addr_t            o_wb_addr,
    output procyon_pkg::wb_data_t            o_wb_data
);

    biu_if biu_bus ();

    ccu_arb u_ccu_arb (
        .i_wb_clk      (i_wb_clk),
        .i_wb_rst      (i_wb_rst),
        .i_fill_req    (i_fill_req),
        .i_fill_addr   (i_fill_addr),
        .i_victim_req  (i_victim_req),
        .i_victim_addr (i_victim_addr),
        .i_victim_data (i_victim_data),
        .o_fill_busy   (o_fill_busy),
        .o_fill_valid  (o_fill_valid),
        .o_fill_addr   (o_fill_addr),
        .o_fill_data   (o_fill_data),
        .o_victim_busy (o_victim_busy),
        .o_victim_done (o_victim_done),
        .biu           (biu_bus.ccu)
    );

    wb_biu u_wb_biu (
        .i_wb_clk   (i_wb_clk),
        .i_wb_rst   (i_wb_rst),
        .i_wb_ack   (i_wb_ack),
        .i_wb_stall (i_wb_stall),
        .i_wb_data  (i_wb_data),
        .o_wb_cyc   (o_wb_cyc),
        .o_wb_stb   (o_wb_stb),
        .o_wb_we    (o_wb_we),
        .o_wb_sel   (o_wb_sel),
        .o_wb_addr  (o_wb_addr),
        .o_wb_data  (o_wb_data),
        .biu        (biu_bus.biu)
    );

endmodule

// ==== tests/wb_mem_model.sv ====
// ########################################
// Wishbone pipelined slave memory, 256 words,
// random stall and ack delay, acks in order
// ########################################

`timescale 1ns/100ps

module wb_mem_model (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_cyc,
    input  logic                  i_stb,
    input  logic                  i_we,
    input  procyon_pkg::wb_addr_t i_addr,
    input  procyon_pkg::wb_data_t i_data,
    output logic                  o_ack,
    output logic                  o_stall,
    output procyon_pkg::wb_data_t o_data
);
    import procyon_pkg::*;

    wb_data_t mem [0:255];
    wb_data_t rsp_q [$];
    wb_addr_t wr_log [$];
    integer   seed = 63;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = wb_data_t'(i * 4) ^ 32'hA5A5_0000;
        end
    end

    always @(posedge i_clk) begin
        o_ack <= 1'b0;
        if (i_rst) begin
            o_stall <= 1'b0;
            o_data  <= '0;
            rsp_q.delete();
        end else begin
            // Beat accepted when not stalled, answered in a later cycle
            if (i_cyc && i_stb && !o_stall) begin
                if (i_we) begin
                    mem[i_addr[9:2]] = i_data;
                    wr_log.push_back(i_addr);
                end
                rsp_q.push_back(mem[i_addr[9:2]]);
            end
            if ((rsp_q.size() > 0) && (($random(seed) & 3) != 0)) begin
                o_ack  <= 1'b1;
                o_data <= rsp_q.pop_front();
            end
            o_stall <= (($random(seed) & 3) == 0);
        end
    end

endmodule

// ==== tests/ccu_checker.sv ====
// ########################################
// Protocol assertions for the cache memory path,
// bound onto the top level
// ########################################

`timescale 1ns/100ps

module ccu_checker (
    input  logic                         i_wb_clk,
    input  logic                         i_wb_rst,
    input  logic                         i_wb_ack,
    input  logic                         i_wb_stall,
    input  logic                         o_wb_cyc,
    input  logic                         o_wb_stb,
    input  procyon_pkg::wb_byte_select_t o_wb_sel,
    input  procyon_pkg::wb_addr_t        o_wb_addr,
    input  procyon_pkg::wb_data_t        o_wb_data,
    input  logic                         o_fill_busy,
    input  logic                         o_fill_valid,
    input  logic                         o_victim_busy,
    input  logic                         o_victim_done
);
    int unsigned num_fails = 0;
    int unsigned ack_count;

    // Acks seen since the last completion pulse
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst || o_fill_valid || o_victim_done) begin
            ack_count <= 0;
        end else if (i_wb_ack && o_wb_cyc) begin
            ack_count <= ack_count + 1;
        end
    end

    reset_idle: assert property (@(posedge i_wb_clk)
        i_wb_rst |=> !(o_wb_cyc || o_wb_stb || o_fill_busy || o_victim_busy
                       || o_fill_valid || o_victim_done))
        else begin
            $error("outputs not idle after reset");
            num_fails++;
        end

    stb_in_cyc: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        o_wb_stb |-> o_wb_cyc)
        else begin
            $error("stb high without cyc");
            num_fails++;
        end

    // A stalled beat keeps its address and data
    stall_hold: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        (o_wb_stb && i_wb_stall) |=> ($stable(o_wb_addr) && $stable(o_wb_data)))
        else begin
            $error("beat changed while stalled");
            num_fails++;
        end

    sel_full: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        o_wb_stb |-> (o_wb_sel == '1))
        else begin
            $error("byte select not all ones");
            num_fails++;
        end

    four_acks: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        (o_fill_valid || o_victim_done) |-> (ack_count == 4))
        else begin
            $error("completion without exactly four acks");
            num_fails++;
        end

    // Busy falls in the very cycle of its completion pulse
    fill_busy_fall: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        o_fill_valid == $fell(o_fill_busy))
        else begin
            $error("fill busy and fill valid out of step");
            num_fails++;
        end

    victim_busy_fall: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        o_victim_done == $fell(o_victim_busy))
        else begin
            $error("victim busy and victim done out of step");
            num_fails++;
        end

endmodule

bind ccu_top ccu_checker u_ccu_checker (
    .i_wb_clk      (i_wb_clk),
    .i_wb_rst      (i_wb_rst),
    .i_wb_ack      (i_wb_ack),
    .i_wb_stall    (i_wb_stall),
    .o_wb_cyc      (o_wb_cyc),
    .o_wb_stb      (o_wb_stb),
    .o_wb_sel      (o_wb_sel),
    .o_wb_addr     (o_wb_addr),
    .o_wb_data     (o_wb_data),
    .o_fill_busy   (o_fill_busy),
    .o_fill_valid  (o_fill_valid),
    .o_victim_busy (o_victim_busy),
    .o_victim_done (o_victim_done)
);

// ==== tests/tb_ccu_top.sv ====
// ########################################
// Testbench for the cache memory path. Runs fills,
// writebacks and mixed traffic against a shadow memory
// ########################################

`timescale 1ns/100ps

`include "procyon_defs.svh"

module tb_ccu_top;
    import procyon_pkg::*;

    logic               clk;
    logic               rst;
    logic               fill_req;
    procyon_addr_t      fill_addr;
    logic               victim_req;
    procyon_addr_t      victim_addr;
    procyon_cacheline_t victim_data;
    logic               fill_busy;
    logic               fill_valid;
    procyon_addr_t      fill_addr_out;
    procyon_cacheline_t fill_data;
    logic               victim_busy;
    logic               victim_done;
    logic               wb_ack;
    logic               wb_stall;
    wb_data_t           wb_rdata;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    wb_byte_select_t    wb_sel;
    wb_addr_t           wb_addr;
    wb_data_t           wb_wdata;

    wb_data_t           shadow [0:255];
    int                 data_errors = 0;
    int                 timeouts = 0;
    integer             seed = 63;

    ccu_top i_dut (
        .i_wb_clk (clk), .i_wb_rst (rst),
        .i_fill_req (fill_req), .i_fill_addr (fill_addr),
        .i_victim_req (victim_req), .i_victim_addr (victim_addr),
        .i_victim_data (victim_data),
        .o_fill_busy (fill_busy), .o_fill_valid (fill_valid),
        .o_fill_addr (fill_addr_out), .o_fill_data (fill_data),
        .o_victim_busy (victim_busy), .o_victim_done (victim_done),
        .i_wb_ack (wb_ack), .i_wb_stall (wb_stall), .i_wb_data (wb_rdata),
        .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_we (wb_we),
        .o_wb_sel (wb_sel), .o_wb_addr (wb_addr), .o_wb_data (wb_wdata)
    );

    wb_mem_model u_mem (
        .i_clk (clk), .i_rst (rst), .i_cyc (wb_cyc), .i_stb (wb_stb),
        .i_we (wb_we), .i_addr (wb_addr), .i_data (wb_wdata),
        .o_ack (wb_ack), .o_stall (wb_stall), .o_data (wb_rdata)
    );

    always #2 clk = ~clk;

    task automatic log_mismatch(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        data_errors++;
    endtask

    // Expected line from the shadow, lowest address in the low word
    function automatic procyon_cacheline_t shadow_line(input procyon_addr_t base);
        procyon_cacheline_t line;
        for (int k = 0; k < 4; k++) begin
            line[k*32 +: 32] = shadow[base[9:2] + k];
        end
        return line;
    endfunction

    task automatic write_shadow(input procyon_addr_t base, input procyon_cacheline_t line);
        for (int k = 0; k < 4; k++) begin
            shadow[base[9:2] + k] = line[k*32 +: 32];
        end
    endtask

    // Called 1 ns after an edge, returns the same way
    task automatic send_request(input logic do_fill, input procyon_addr_t faddr,
                                input logic do_victim, input procyon_addr_t vaddr,
                                input procyon_cacheline_t vdata);
        fill_req    = do_fill;
        fill_addr   = faddr;
        victim_req  = do_victim;
        victim_addr = vaddr;
        victim_data = vdata;
        @(posedge clk);
        #1;
        fill_req   = 1'b0;
        victim_req = 1'b0;
    endtask

    task automatic expect_completion(input logic want_fill, input procyon_addr_t base);
        int  cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && (cycles < 500)) begin
            @(posedge clk);
            #1;
            seen = fill_valid | victim_done;
            cycles++;
        end
        if (!seen) begin
            $display("Timeout: no completion pulse within 500 cycles");
            timeouts++;
        end else begin
            assert (fill_valid == want_fill && victim_done == !want_fill)
                else log_mismatch("completion pulse of the wrong kind");
            if (fill_valid) begin
                assert (fill_addr_out == base)
                    else log_mismatch($sformatf("fill address %h, expected %h",
                                                fill_addr_out, base));
                assert (fill_data == shadow_line(base))
                    else log_mismatch($sformatf("fill data %h, expected %h",
                                                fill_data, shadow_line(base)));
            end
        end
    endtask

    initial begin
        procyon_cacheline_t vdata;
        procyon_addr_t      addr;
        int                 kind;
        int                 log_start;
        int                 total;
        clk = 1'b0;
        rst = 1'b1;
        fill_req = 1'b0;
        fill_addr = '0;
        victim_req = 1'b0;
        victim_addr = '0;
        victim_data = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = wb_data_t'(i * 4) ^ 32'hA5A5_0000;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;

        // Unaligned fill of a line nobody has written
        send_request(1'b1, 32'h0000_0047, 1'b0, '0, '0);
        expect_completion(1'b1, 32'h0000_0040);

        // Writeback and fill of one line in the same cycle
        vdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
        log_start = u_mem.wr_log.size();
        write_shadow(32'h0000_0100, vdata);
        send_request(1'b1, 32'h0000_010A, 1'b1, 32'h0000_0105, vdata);
        expect_completion(1'b0, 32'h0000_0100);
        expect_completion(1'b1, 32'h0000_0100);
        assert (u_mem.wr_log.size() == log_start + 4)
            else log_mismatch("writeback did not give four write beats");
        if (u_mem.wr_log.size() >= log_start + 4) begin
            for (int k = 0; k < 4; k++) begin
                assert (u_mem.wr_log[log_start + k] == 32'h0000_0100 + 4 * k)
                    else log_mismatch($sformatf("write beat %0d at %h", k,
                                                u_mem.wr_log[log_start + k]));
            end
        end

        // Second fill pulse while busy must be dropped
        send_request(1'b1, 32'h0000_0200, 1'b0, '0, '0);
        send_request(1'b1, 32'h0000_0300, 1'b0, '0, '0);
        expect_completion(1'b1, 32'h0000_0200);
        repeat (20) begin
            @(posedge clk);
            #1;
            assert (!fill_valid && !fill_busy)
                else log_mismatch("ignored fill pulse was served");
        end

        // Mixed traffic, each request issued as soon as the last completes
        for (int n = 0; n < 20; n++) begin
            kind = $unsigned($random(seed)) % 3;
            addr = procyon_addr_t'($unsigned($random(seed)) % 1024);
            vdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
            if (kind != 0) begin
                write_shadow(addr & ~32'hF, vdata);
            end
            send_request(kind != 1, addr, kind != 0, addr, vdata);
            if (kind != 0) begin
                expect_completion(1'b0, addr & ~32'hF);
            end
            if (kind != 1) begin
                expect_completion(1'b1, addr & ~32'hF);
            end
        end

        repeat (5) @(posedge clk);
        total = data_errors + timeouts + i_dut.u_ccu_checker.num_fails;
        $display("Run finished: %0d data errors, %0d timeouts, %0d assertion failures",
                 data_errors, timeouts, i_dut.u_ccu_checker.num_fails);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+common
common/procyon_pkg.sv
common/biu_if.sv
ccu/ccu_arb.sv
wb_biu/wb_biu.sv
verilog/ccu_top.sv
tests/wb_mem_model.sv
tests/ccu_checker.sv
tests/tb_ccu_top.sv
